/* compile.f */
common/multPkg.sv
verilog/inputSync.sv
multiplier/multControl.sv
multiplier/multDatapath.sv
verilog/hexDisplay.sv
verilog/multTop.sv
sim/multTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the multiplier testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module multTb -o multTbSim

# the simulator exits nonzero on a failed check; the log search decides the result
./obj_dir/multTbSim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* sim/multTb.sv */
// ================================================
// directed testbench for the signed multiplier,
// presses the buttons and checks A:B, sign and display
// ================================================
`timescale 1ns/10ps

module multTb;

	// roughly 40 cycles per button operation, about 100 operations in all
	localparam int numOps     = 100;
	localparam int cycleLimit = 40 * numOps + 400;

	logic          clk;
	logic          arstN;
	logic          clearLoadN;
	logic          runN;
	multPkg::byteT sw;
	multPkg::byteT aVal;
	multPkg::byteT bVal;
	logic          signLed;
	multPkg::segT  hexSeg;
	logic [3:0]    hexGrid;

	int          cycleCount;
	logic [31:0] rngState;

	multTop #(
		.scanBits   (2), // digit changes every 4 cycles
		.syncStages (2)
	) i_multTop (
		.clk        (clk),
		.arstN      (arstN),
		.clearLoadN (clearLoadN),
		.runN       (runN),
		.sw         (sw),
		.aVal       (aVal),
		.bVal       (bVal),
		.signLed    (signLed),
		.hexSeg     (hexSeg),
		.hexGrid    (hexGrid)
	);

	always #5 clk = ~clk;

	// watchdog so a stuck FSM cannot hang the run
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout, the tests did not finish within %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$fatal(1, "simulation stopped by the watchdog");
		end
	end

	task automatic checkVal(input string name, input logic [15:0] got,
			input logic [15:0] expVal);
		if (got !== expVal) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, expVal);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] xorshiftNext(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// sign extend both operands, the low 16 bits are the signed product
	function automatic logic [15:0] productRef(input multPkg::byteT mulB,
			input multPkg::byteT mulS);
		return {{8{mulB[7]}}, mulB} * {{8{mulS[7]}}, mulS};
	endfunction

	// active low gfedcba with the point dark
	function automatic multPkg::segT segFor(input logic [3:0] nib);
		case (nib)
			4'h0:    return 8'hC0;
			4'h1:    return 8'hF9;
			4'h2:    return 8'hA4;
			4'h3:    return 8'hB0;
			4'h4:    return 8'h99;
			4'h5:    return 8'h92;
			4'h6:    return 8'h82;
			4'h7:    return 8'hF8;
			4'h8:    return 8'h80;
			4'h9:    return 8'h90;
			4'hA:    return 8'h88;
			4'hB:    return 8'h83;
			4'hC:    return 8'hC6;
			4'hD:    return 8'hA1;
			4'hE:    return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic pressClearLoad();
		clearLoadN = 1'b0;
		waitCycles(6);
		clearLoadN = 1'b1;
		waitCycles(4); // release passes the synchronizer
	endtask

	task automatic pressRun(input int holdCycles);
		runN = 1'b0;
		waitCycles(holdCycles);
		runN = 1'b1;
	endtask

	// product is final 20 cycles after the press, 30 after release is well past it
	task automatic waitDone();
		waitCycles(30);
	endtask

	task automatic loadMultiplier(input multPkg::byteT mulB);
		sw = mulB;
		waitCycles(3); // switches settle before the load pulse
		pressClearLoad();
		// a load also clears X:A, whatever the previous run left there
		checkVal("bVal", 16'(bVal), 16'(mulB));
		checkVal("aVal", 16'(aVal), 16'h0);
		checkVal("signLed", 16'(signLed), 16'h0);
	endtask

	task automatic checkProduct(input multPkg::byteT mulB, input multPkg::byteT mulS);
		logic [15:0] expProd;
		logic        expSign;
		expProd = productRef(mulB, mulS);
		expSign = (expProd == 16'h0) ? 1'b0 : expProd[15];
		checkVal("product", {aVal, bVal}, expProd);
		checkVal("signLed", 16'(signLed), 16'(expSign));
	endtask

	task automatic runAndCheck(input multPkg::byteT mulB, input multPkg::byteT mulS,
			input int holdCycles);
		sw = mulS;
		waitCycles(3);
		pressRun(holdCycles);
		waitDone();
		checkProduct(mulB, mulS);
	endtask

	task automatic testResetAndLoad();
		checkVal("aVal", 16'(aVal), 16'h0);
		checkVal("bVal", 16'(bVal), 16'h0);
		checkVal("signLed", 16'(signLed), 16'h0);
		loadMultiplier(8'hA5);
	endtask

	task automatic testDirectedProducts();
		multPkg::byteT listB [6];
		multPkg::byteT listS [6];
		listB = '{8'h00, 8'h07, 8'hFF, 8'h80, 8'h7F, 8'hFB};
		listS = '{8'h05, 8'h03, 8'hFF, 8'h80, 8'h80, 8'h09};
		for (int i = 0; i < 6; i++) begin
			loadMultiplier(listB[i]);
			runAndCheck(listB[i], listS[i], 6);
		end
	endtask

	task automatic testRandomProducts();
		multPkg::byteT mulB;
		multPkg::byteT mulS;
		for (int i = 0; i < 40; i++) begin
			rngState = xorshiftNext(rngState);
			mulB     = rngState[7:0];
			rngState = xorshiftNext(rngState);
			mulS     = rngState[7:0];
			loadMultiplier(mulB);
			runAndCheck(mulB, mulS, 6);
		end
	endtask

	task automatic testChainedRun();
		multPkg::byteT prevLow;
		logic [15:0]   firstProd;
		firstProd = productRef(8'hF3, 8'h1D);
		prevLow   = firstProd[7:0]; // low product byte stays in B as the next multiplier
		loadMultiplier(8'hF3);
		runAndCheck(8'hF3, 8'h1D, 6);
		runAndCheck(prevLow, 8'hC6, 6);
	endtask

	task automatic testHeldRun();
		loadMultiplier(8'h0D);
		runAndCheck(8'h0D, 8'hB7, 60); // a restart would give S times the low byte
	endtask

	task automatic testDisplay();
		logic [15:0] shown;
		logic [3:0]  seen;
		int          k;
		seen = 4'h0;
		for (int c = 0; c < 64; c++) begin
			waitCycles(1);
			shown = {aVal, bVal};
			case (hexGrid)
				4'b1110: k = 0;
				4'b1101: k = 1;
				4'b1011: k = 2;
				4'b0111: k = 3;
				default: k = -1;
			endcase
			if (k >= 0) begin
				checkVal("hexSeg", 16'(hexSeg), 16'(segFor(shown[4*k +: 4])));
				seen[k] = 1'b1;
			end
		end
		checkVal("digitsSeen", 16'(seen), 16'h000F); // every digit must light up once
	endtask

	initial begin
		clk        = 1'b0;
		arstN      = 1'b0;
		clearLoadN = 1'b1;
		runN       = 1'b1;
		sw         = '0;
		cycleCount = 0;
		rngState   = 32'd25;
		waitCycles(3);
		arstN = 1'b1;
		waitCycles(2);

		testResetAndLoad();
		testDirectedProducts();
		testRandomProducts();
		testChainedRun();
		testHeldRun();
		testDisplay();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* verilog/multTop.sv */
// ================================================
// top of the push-button multiplier, chains input
// sync, FSM, datapath and display
// ================================================
`timescale 1ns/10ps

module multTop #(
	parameter int scanBits   = 16, // display scan rate, small in simulation
	parameter int syncStages = 2
) (
	input  logic          clk,
	input  logic          arstN,
	input  logic          clearLoadN, // active low clear/load button
	input  logic          runN,       // active low run button
	input  multPkg::byteT sw,
	output multPkg::byteT aVal,
	output multPkg::byteT bVal,
	output logic          signLed,
	output multPkg::segT  hexSeg,
	output logic [3:0]    hexGrid
);

	logic          loadPulse;
	logic          startPulse;
	logic          runHeld;
	multPkg::byteT swSync;
	logic          clearA;
	logic          loadB;
	logic          addEn;
	logic          subEn;
	logic          shiftEn;
	logic          xVal;
	logic          bitM;

	inputSync #(.syncStages(syncStages)) i_inputSync (
		.clk        (clk),
		.arstN      (arstN),
		.clearLoadN (clearLoadN),
		.runN       (runN),
		.sw         (sw),
		.loadPulse  (loadPulse),
		.startPulse (startPulse),
		.runHeld    (runHeld),
		.swSync     (swSync)
	);

	multControl i_multControl (
		.clk        (clk),
		.arstN      (arstN),
		.loadPulse  (loadPulse),
		.startPulse (startPulse),
		.runHeld    (runHeld),
		.bitM       (bitM),
		.clearA     (clearA),
		.loadB      (loadB),
		.addEn      (addEn),
		.subEn      (subEn),
		.shiftEn    (shiftEn)
	);

	multDatapath i_multDatapath (
		.clk     (clk),
		.arstN   (arstN),
		.clearA  (clearA),
		.loadB   (loadB),
		.addEn   (addEn),
		.subEn   (subEn),
		.shiftEn (shiftEn),
		.swSync  (swSync),
		.aVal    (aVal),
		.bVal    (bVal),
		.xVal    (xVal),
		.bitM    (bitM)
	);

	hexDisplay #(.scanBits(scanBits)) i_hexDisplay (
		.clk     (clk),
		.arstN   (arstN),
		.aVal    (aVal),
		.bVal    (bVal),
		.hexSeg  (hexSeg),
		.hexGrid (hexGrid)
	);

	assign signLed = xVal; // X holds the product sign once the run is done

endmodule

/* verilog/hexDisplay.sv */
// ================================================
// four-digit multiplexed seven-segment driver,
// A on the upper digits and B on the lower
// ================================================
`timescale 1ns/10ps

module hexDisplay #(
	parameter int scanBits = 16 // each digit stays lit for 2**scanBits cycles
) (
	input  logic          clk,
	input  logic          arstN,
	input  multPkg::byteT aVal,
	input  multPkg::byteT bVal,
	output multPkg::segT  hexSeg,  // active low, bit 7 is the point
	output logic [3:0]    hexGrid  // one-hot active low digit select
);

	logic [scanBits+1:0] scanCnt; // top two bits pick the digit
	logic [1:0]          digitSel;
	multPkg::nibbleT     nibble;
	multPkg::segT        segNext;

	assign digitSel = scanCnt[scanBits+1:scanBits];

	always_comb begin
		case (digitSel)
			2'd0:    nibble = bVal[3:0];
			2'd1:    nibble = bVal[7:4];
			2'd2:    nibble = aVal[3:0];
			default: nibble = aVal[7:4];
		endcase
	end

	// active low segments gfedcba, point kept dark
	always_comb begin
		case (nibble)
			4'h0:    segNext = 8'hC0;
			4'h1:    segNext = 8'hF9;
			4'h2:    segNext = 8'hA4;
			4'h3:    segNext = 8'hB0;
			4'h4:    segNext = 8'h99;
			4'h5:    segNext = 8'h92;
			4'h6:    segNext = 8'h82;
			4'h7:    segNext = 8'hF8;
			4'h8:    segNext = 8'h80;
			4'h9:    segNext = 8'h90;
			4'hA:    segNext = 8'h88;
			4'hB:    segNext = 8'h83;
			4'hC:    segNext = 8'hC6;
			4'hD:    segNext = 8'hA1;
			4'hE:    segNext = 8'h86;
			default: segNext = 8'h8E;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			scanCnt <= '0;
			hexSeg  <= 8'hFF;   // all segments off until the first scan
			hexGrid <= 4'b1110; // digit 0
		end else begin
			scanCnt <= scanCnt + 1'b1;
			// pattern and grid are registered in the same edge so they never disagree
			hexSeg  <= segNext;
			hexGrid <= ~(4'b0001 << digitSel);
		end
	end

endmodule

/* multiplier/multDatapath.sv */
// ================================================
// X, A and B registers with the 9-bit adder and
// subtractor, driven by the FSM strobes
// ================================================
`timescale 1ns/10ps

module multDatapath (
	input  logic          clk,
	input  logic          arstN,
	input  logic          clearA,  // zero X and A
	input  logic          loadB,   // take B from the switches
	input  logic          addEn,   // X:A gets A + S
	input  logic          subEn,   // X:A gets A - S
	input  logic          shiftEn, // arithmetic shift right of X:A:B
	input  multPkg::byteT swSync,  // multiplicand S
	output multPkg::byteT aVal,
	output multPkg::byteT bVal,
	output logic          xVal,
	output logic          bitM
);

	logic          xReg; // sign of the running partial product
	multPkg::byteT aReg;
	multPkg::byteT bReg;
	multPkg::sumT  aExt;
	multPkg::sumT  sExt;
	multPkg::sumT  addOperand;
	multPkg::sumT  sum;

	// both operands are sign extended to 9 bits so the sum cannot overflow
	assign aExt = {aReg[multPkg::dataWidth-1], aReg};
	assign sExt = {swSync[multPkg::dataWidth-1], swSync};

	// two's complement subtraction, invert S and add a carry-in of 1
	assign addOperand = subEn ? ~sExt : sExt;
	assign sum        = aExt + addOperand + multPkg::sumT'(subEn);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			xReg <= 1'b0;
			aReg <= '0;
			bReg <= '0;
		end else begin
			if (clearA) begin
				xReg <= 1'b0;
				aReg <= '0;
			end else if (addEn || subEn) begin
				xReg <= sum[multPkg::dataWidth];
				aReg <= sum[multPkg::dataWidth-1:0];
			end else if (shiftEn) begin
				// X stays put and refills the top of A, keeping the sign
				aReg <= {xReg, aReg[multPkg::dataWidth-1:1]};
			end

			if (loadB)
				bReg <= swSync;
			else if (shiftEn)
				bReg <= {aReg[0], bReg[multPkg::dataWidth-1:1]}; // low product bits move in
		end
	end

	assign aVal = aReg;
	assign bVal = bReg;
	assign xVal = xReg;
	assign bitM = bReg[0]; // next multiplier bit to examine

endmodule

/* multiplier/multControl.sv */
// ================================================
// FSM that sequences clear, add, subtract and shift
// strobes for the 8-step signed multiply
// ================================================
`timescale 1ns/10ps

module multControl (
	input  logic clk,
	input  logic arstN,
	input  logic loadPulse,  // clear/load press
	input  logic startPulse, // run press
	input  logic runHeld,
	input  logic bitM,       // current multiplier bit, B bit 0
	output logic clearA,
	output logic loadB,
	output logic addEn,
	output logic subEn,
	output logic shiftEn
);

	multPkg::ctrlStateT state;
	multPkg::ctrlStateT stateNext;
	logic [2:0] stepCnt; // which add/shift pair is running, 0 to 7
	logic lastStep;

	assign lastStep = (stepCnt == 3'd7);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state   <= multPkg::stIdle;
			stepCnt <= 3'd0;
		end else begin
			state <= stateNext;
			if (state == multPkg::stClear)
				stepCnt <= 3'd0;
			else if (state == multPkg::stShift)
				stepCnt <= stepCnt + 3'd1; // wraps after the eighth shift, unused then
		end
	end

	always_comb begin
		stateNext = state;
		clearA    = 1'b0;
		loadB     = 1'b0;
		addEn     = 1'b0;
		subEn     = 1'b0;
		shiftEn   = 1'b0;
		case (state)
			multPkg::stIdle: begin
				// a clear/load press resets X:A and takes B from the switches in one cycle
				clearA = loadPulse;
				loadB  = loadPulse;
				if (startPulse)
					stateNext = multPkg::stClear;
			end
			multPkg::stClear: begin
				clearA    = 1'b1; // product starts from zero, B keeps the multiplier
				stateNext = multPkg::stAdd;
			end
			multPkg::stAdd: begin
				// skip the arithmetic when the multiplier bit is 0
				// the top bit of B has negative weight, so the last step subtracts
				addEn     = bitM & ~lastStep;
				subEn     = bitM & lastStep;
				stateNext = multPkg::stShift;
			end
			multPkg::stShift: begin
				shiftEn   = 1'b1;
				stateNext = lastStep ? multPkg::stHold : multPkg::stAdd;
			end
			multPkg::stHold: begin
				if (!runHeld)
					stateNext = multPkg::stIdle; // one multiplication per press
			end
			default: stateNext = multPkg::stIdle;
		endcase
	end

endmodule

/* verilog/inputSync.sv */
// ================================================
// synchronizes buttons and switches, turns button
// presses into single-cycle pulses for the FSM
// ================================================
`timescale 1ns/10ps

module inputSync #(
	parameter int syncStages = 2 // flops per synchronizer chain, at least 2
) (
	input  logic         clk,
	input  logic         arstN,
	input  logic         clearLoadN, // active low button
	input  logic         runN,       // active low button
	input  multPkg::byteT sw,
	output logic         loadPulse,
	output logic         startPulse,
	output logic         runHeld,
	output multPkg::byteT swSync
);

	// bit 1 is clear/load and bit 0 is run, so both buttons share one chain
	logic [1:0] btnChain [syncStages];
	multPkg::byteT swChain [syncStages];
	logic [1:0] btnLevel; // synchronized button levels, still active low
	logic [1:0] btnPrev;  // level one cycle earlier
	logic [1:0] btnFall;  // registered falling edge, one cycle wide

	assign btnLevel = btnChain[syncStages-1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			// buttons come out of reset as released so no edge fires
			for (int i = 0; i < syncStages; i++) begin
				btnChain[i] <= 2'b11;
				swChain[i]  <= '0;
			end
			btnPrev <= 2'b11;
			btnFall <= 2'b00;
		end else begin
			btnChain[0] <= {clearLoadN, runN};
			swChain[0]  <= sw;
			for (int i = 1; i < syncStages; i++) begin
				btnChain[i] <= btnChain[i-1];
				swChain[i]  <= swChain[i-1];
			end
			btnPrev <= btnLevel;
			btnFall <= btnPrev & ~btnLevel; // high to low means pressed
		end
	end

	assign loadPulse  = btnFall[1];
	assign startPulse = btnFall[0];
	assign runHeld    = ~btnLevel[0]; // level stays up while the run button is held
	assign swSync     = swChain[syncStages-1];

endmodule

/* common/multPkg.sv */
// ================================================
// shared widths, vector types and the FSM state
// encoding for the push-button signed multiplier
// ================================================

package multPkg;

	// operand width, the display assumes two hex digits per register
	parameter int dataWidth = 8;

	// operand and register values S, A and B
	typedef logic [dataWidth-1:0] byteT;

	// sign-extended adder operands and the 9-bit sum
	typedef logic [dataWidth:0] sumT;

	typedef logic [3:0] nibbleT; // one hex digit

	// segment pattern, active low, bit 7 is the decimal point
	typedef logic [7:0] segT;

	// control sequence: idle, clear A, then eight add/shift pairs, then wait for release
	typedef enum logic [2:0] {
		stIdle,
		stClear,
		stAdd,
		stShift,
		stHold
	} ctrlStateT;

endpackage
